//--- flist.f
hdl/cpu_types_pkg.sv
hdl/regfile_pkg.sv
hdl/regfile_ram.sv
hdl/regfile_wr_arbiter.sv
hdl/alu_unit.sv
hdl/byte_insert_unit.sv
hdl/regfile_top.sv
tb/regfile_tb.sv

//--- hdl/alu_unit.sv
`default_nettype none

module alu_unit
   import cpu_types_pkg::*;
   import regfile_pkg::*;
(
   input  logic       clka,
   input  logic       reset,
   input  logic       issue_req,
   input  alu_issue_t issue_pkt,
   output logic       issue_ack,  // High once the result is in the file
   output logic       wr_req,
   output rf_wr_t     wr_pkt,
   input  logic       wr_ack
);

   typedef enum logic [2:0] {
      st_idle,
      st_exec,     // Operands latched, result computed this cycle
      st_write,    // Waiting for the arbiter
      st_done,     // Issue ack high until the source drops req
      st_release   // Waits for the arbiter to drop its ack
   } unit_state_e;

   unit_state_e state;
   alu_issue_t  issue_q;  // Issue packet as latched
   value_t      result;
   rf_wr_t      wr_q;     // Outgoing write request

   // Operation select
   always_comb begin
      case (issue_q.op)
         alu_add: result = issue_q.a + issue_q.b;
         alu_sub: result = issue_q.a - issue_q.b;
         alu_and: result = issue_q.a & issue_q.b;
         alu_or:  result = issue_q.a | issue_q.b;
         alu_xor: result = issue_q.a ^ issue_q.b;
         alu_shl: result = issue_q.a << issue_q.b[SHAMT_W-1:0];  // Low 5 bits of b only
         default: result = '0;
      endcase
   end

   always_ff @(posedge clka) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:    if (issue_req) state <= st_exec;
            st_exec:    state <= st_write;
            st_write:   if (wr_ack) state <= st_done;  // Write has committed
            st_done:    if (!issue_req) state <= st_release;
            st_release: if (!wr_ack) state <= st_idle;
            default:    state <= st_idle;
         endcase
      end
   end

   // Payload registers
   always_ff @(posedge clka) begin
      if (state == st_idle && issue_req) begin
         issue_q <= issue_pkt;
      end
      if (state == st_exec) begin
         wr_q.dst        <= issue_q.dst;
         wr_q.be         <= '1;       // Whole word plus tag
         wr_q.word.tag   <= src_alu;
         wr_q.word.value <= result;
      end
   end

   assign wr_req    = (state == st_write);
   assign wr_pkt    = wr_q;
   assign issue_ack = (state == st_done);

endmodule : alu_unit

`default_nettype wire

//--- hdl/byte_insert_unit.sv
`default_nettype none

module byte_insert_unit
   import cpu_types_pkg::*;
   import regfile_pkg::*;
(
   input  logic        clka,
   input  logic        reset,
   input  logic        issue_req,
   input  bins_issue_t issue_pkt,
   output logic        issue_ack,
   output logic        wr_req,
   output rf_wr_t      wr_pkt,
   input  logic        wr_ack
);

   typedef enum logic [2:0] {
      st_idle,
      st_exec,
      st_write,
      st_done,
      st_release
   } unit_state_e;

   unit_state_e state;
   bins_issue_t issue_q;
   rf_be_t      lane_be;  // Selected value lane plus the tag lane
   rf_wr_t      wr_q;

   always_comb begin
      lane_be               = '0;
      lane_be[issue_q.lane] = 1'b1;
      lane_be[TAG_LANE]     = 1'b1;  // Tag always records the writer
   end

   // ==============================
   // Handshake FSM
   // ==============================

   always_ff @(posedge clka) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle:    if (issue_req) state <= st_exec;
            st_exec:    state <= st_write;
            st_write:   if (wr_ack) state <= st_done;
            st_done:    if (!issue_req) state <= st_release;  // Source may hold req
            st_release: if (!wr_ack) state <= st_idle;
            default:    state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clka) begin
      if (state == st_idle && issue_req) begin
         issue_q <= issue_pkt;
      end
      // The byte is copied into every lane, the mask picks the one that lands
      if (state == st_exec) begin
         wr_q.dst        <= issue_q.dst;
         wr_q.be         <= lane_be;
         wr_q.word.tag   <= src_binsert;
         wr_q.word.value <= {VALUE_BYTES{issue_q.data}};
      end
   end

   assign wr_req    = (state == st_write);
   assign wr_pkt    = wr_q;
   assign issue_ack = (state == st_done);

endmodule : byte_insert_unit

`default_nettype wire

//--- hdl/cpu_types_pkg.sv
`default_nettype none

// ==============================
// Core machine types
// ==============================

package cpu_types_pkg;

   // Width of one machine value in bits
   localparam int VALUE_W = 32;

   // Number of byte lanes in one machine value
   localparam int VALUE_BYTES = VALUE_W / 8;

   // Bits needed to select a byte lane within a value
   localparam int LANE_W = $clog2(VALUE_BYTES);

   // Shift amounts use only the bits needed to cover one value
   localparam int SHAMT_W = $clog2(VALUE_W);

   // Physical register index width; 64 entries at most
   localparam int PREG_W = 6;

   // One machine value as seen by the execute units
   typedef logic [VALUE_W-1:0] value_t;

   // Physical register index used by both units and the top level
   typedef logic [PREG_W-1:0] preg_t;

   // A single byte lane selector
   typedef logic [LANE_W-1:0] lane_t;

endpackage : cpu_types_pkg

`default_nettype wire

//--- hdl/regfile_pkg.sv
`default_nettype none

// ==============================
// Register file subsystem types
// ==============================

package regfile_pkg;

   import cpu_types_pkg::*;

   localparam int NUM_PEERS = 2;  // ALU and byte-insert share the write port

   // The tag byte sits just above the value bytes in every RAM word
   localparam int TAG_LANE = VALUE_BYTES;
   localparam int RF_LANES = VALUE_BYTES + 1;  // Four value lanes plus the tag lane

   typedef logic [RF_LANES-1:0] rf_be_t;  // One write enable per RAM byte lane

   // Code written into the tag byte, telling which unit produced the entry
   typedef enum logic [7:0] {
      src_none    = 8'h00,  // Never written since power-up
      src_alu     = 8'ha1,
      src_binsert = 8'hb1
   } src_tag_e;

   // ALU opcodes carried in the issue packet
   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_shl   // Shift left by the low bits of operand b
   } alu_op_e;

   // One RAM word; tag in the top byte
   typedef struct packed {
      src_tag_e tag;
      value_t   value;
   } rf_word_t;

   // Write request from a unit to the arbiter
   typedef struct packed {
      preg_t    dst;
      rf_be_t   be;    // Lanes to update, others keep their contents
      rf_word_t word;
   } rf_wr_t;

   // Issue packet for the ALU, operands arrive with it
   typedef struct packed {
      alu_op_e op;
      value_t  a;
      value_t  b;
      preg_t   dst;
   } alu_issue_t;

   // Issue packet for the byte-insert unit
   typedef struct packed {
      preg_t       dst;
      lane_t       lane;  // Value byte to replace
      logic [7:0]  data;
   } bins_issue_t;

endpackage : regfile_pkg

`default_nettype wire

//--- hdl/regfile_ram.sv
`default_nettype none

module regfile_ram
   import cpu_types_pkg::*;
   import regfile_pkg::*;
#(
   parameter int PREGS = 64
) (
   input  logic     clka,
   input  logic     ena,    // Write port enable
   input  rf_be_t   wea,    // Byte lane enables, tag lane on top
   input  preg_t    addra,
   input  rf_word_t dina,
   input  preg_t    addrb,
   output rf_word_t doutb
);

   // Only the low address bits are decoded when the file is shallower than 64
   localparam int AW = $clog2(PREGS);

   rf_word_t    mem [PREGS];
   logic [AW-1:0] raddrb;  // Read address captured on the clock edge

   // Power-up contents are all zero, tag reads as src_none
   initial begin
      for (int i = 0; i < PREGS; i++) begin
         mem[i] = '{tag: src_none, value: '0};
      end
   end

   // ==============================
   // Write port
   // ==============================

   // Each byte lane is written on its own so partial updates merge with
   // the bytes already stored in the entry
   always_ff @(posedge clka) begin
      for (int g = 0; g < RF_LANES; g++) begin
         if (ena && wea[g]) begin
            mem[addra[AW-1:0]][g*8 +: 8] <= dina[g*8 +: 8];  // Only enabled lanes change
         end
      end
   end

   // ==============================
   // Read port
   // ==============================

   always_ff @(posedge clka) begin
      raddrb <= addrb[AW-1:0];  // Address is sampled, data follows one cycle later
   end

   assign doutb = mem[raddrb];  // Reflects a write committed on the same edge

endmodule : regfile_ram

`default_nettype wire

//--- hdl/regfile_top.sv
`default_nettype none

module regfile_top
   import cpu_types_pkg::*;
   import regfile_pkg::*;
#(
   parameter int PREGS = 64  // Register depth, 32 also works
) (
   input  logic        clka,
   input  logic        reset,
   // ALU issue port
   input  logic        alu_req,
   input  alu_issue_t  alu_pkt,
   output logic        alu_ack,
   // Byte-insert issue port
   input  logic        bins_req,
   input  bins_issue_t bins_pkt,
   output logic        bins_ack,
   // Read port, no handshake
   input  preg_t       rd_addr,
   output rf_word_t    rd_data
);

   // Arbiter slot of each unit
   localparam int PEER_ALU  = 0;
   localparam int PEER_BINS = 1;

   logic   [NUM_PEERS-1:0] wr_req;
   rf_wr_t [NUM_PEERS-1:0] wr_pkt;
   logic   [NUM_PEERS-1:0] wr_ack;

   // RAM write port, driven by the arbiter alone
   logic     ram_en;
   rf_be_t   ram_we;
   preg_t    ram_addr;
   rf_word_t ram_data;

   // ==============================
   // Execute units
   // ==============================

   alu_unit i_alu (
      .clka      (clka),
      .reset     (reset),
      .issue_req (alu_req),
      .issue_pkt (alu_pkt),
      .issue_ack (alu_ack),
      .wr_req    (wr_req[PEER_ALU]),
      .wr_pkt    (wr_pkt[PEER_ALU]),
      .wr_ack    (wr_ack[PEER_ALU])
   );

   byte_insert_unit i_bins (
      .clka      (clka),
      .reset     (reset),
      .issue_req (bins_req),
      .issue_pkt (bins_pkt),
      .issue_ack (bins_ack),
      .wr_req    (wr_req[PEER_BINS]),
      .wr_pkt    (wr_pkt[PEER_BINS]),
      .wr_ack    (wr_ack[PEER_BINS])
   );

   // ==============================
   // Write arbitration and storage
   // ==============================

   regfile_wr_arbiter i_arb (
      .clka     (clka),
      .reset    (reset),
      .wr_req   (wr_req),
      .wr_pkt   (wr_pkt),
      .wr_ack   (wr_ack),
      .ram_en   (ram_en),
      .ram_we   (ram_we),
      .ram_addr (ram_addr),
      .ram_data (ram_data)
   );

   regfile_ram #(
      .PREGS (PREGS)
   ) i_ram (
      .clka  (clka),
      .ena   (ram_en),
      .wea   (ram_we),
      .addra (ram_addr),
      .dina  (ram_data),
      .addrb (rd_addr),   // Read is served straight from outside
      .doutb (rd_data)
   );

endmodule : regfile_top

`default_nettype wire

//--- hdl/regfile_wr_arbiter.sv
`default_nettype none

module regfile_wr_arbiter
   import cpu_types_pkg::*;
   import regfile_pkg::*;
(
   input  logic                   clka,
   input  logic                   reset,
   input  logic   [NUM_PEERS-1:0] wr_req,  // One request line per peer
   input  rf_wr_t [NUM_PEERS-1:0] wr_pkt,  // Held steady while the request is up
   output logic   [NUM_PEERS-1:0] wr_ack,
   output logic                   ram_en,
   output rf_be_t                 ram_we,
   output preg_t                  ram_addr,
   output rf_word_t               ram_data
);

   localparam int PW = (NUM_PEERS > 1) ? $clog2(NUM_PEERS) : 1;

   typedef enum logic [1:0] {
      st_idle,     // Waiting for any request
      st_write,    // Drives the RAM for exactly one cycle
      st_ack,      // Ack to the winner until it drops its request
      st_release   // Ack has fallen, one spare cycle before the next grant
   } arb_state_e;

   arb_state_e    state;
   logic [PW-1:0] ptr;       // Peer with the highest priority this round
   logic [PW-1:0] grant;     // Peer being served
   logic [PW-1:0] pick;      // Winner of the current search
   logic          pick_vld;
   rf_wr_t        wr_q;      // Copy of the winning request

   // Round-robin search starting at the pointer
   always_comb begin : search
      int idx;
      pick     = ptr;
      pick_vld = 1'b0;
      for (int i = 0; i < NUM_PEERS; i++) begin
         idx = (int'(ptr) + i) % NUM_PEERS;
         if (!pick_vld && wr_req[idx]) begin
            pick_vld = 1'b1;
            pick     = idx[PW-1:0];
         end
      end
   end

   // ==============================
   // Grant FSM
   // ==============================

   always_ff @(posedge clka) begin
      if (reset) begin
         state <= st_idle;
         ptr   <= '0;  // Peer 0 is favoured first
         grant <= '0;
      end else begin
         case (state)
            st_idle: begin
               if (pick_vld) begin
                  grant <= pick;
                  // The winner drops to lowest priority next round
                  ptr   <= (pick == PW'(NUM_PEERS - 1)) ? '0 : pick + 1'b1;
                  state <= st_write;
               end
            end
            st_write:   state <= st_ack;
            st_ack:     if (!wr_req[grant]) state <= st_release;  // Peer saw the ack
            st_release: state <= st_idle;
            default:    state <= st_idle;
         endcase
      end
   end

   // Request is captured at grant time
   always_ff @(posedge clka) begin
      if (state == st_idle && pick_vld) begin
         wr_q <= wr_pkt[pick];
      end
   end

   assign ram_en   = (state == st_write);
   assign ram_we   = ram_en ? wr_q.be : '0;  // No lane is touched outside the write cycle
   assign ram_addr = wr_q.dst;
   assign ram_data = wr_q.word;

   always_comb begin
      wr_ack = '0;
      if (state == st_ack) begin
         wr_ack[grant] = 1'b1;  // Only the served peer sees an ack
      end
   end

endmodule : regfile_wr_arbiter

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the register file testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps --top-module regfile_tb \
   -f flist.f -o regfile_sim &&
./obj_dir/regfile_sim | grep -F "No errors" ||
{ echo "Simulation failed"; exit 1; }

//--- tb/regfile_tb.sv
`default_nettype none

module regfile_tb
   import cpu_types_pkg::*;
   import regfile_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int PREGS      = 64;
   localparam int WAIT_LIMIT = 64;  // Cycles allowed for one edge of any ack

   logic        clka = 1'b0;
   logic        reset;
   logic        alu_req;
   alu_issue_t  alu_pkt;
   logic        alu_ack;
   logic        bins_req;
   bins_issue_t bins_pkt;
   logic        bins_ack;
   preg_t       rd_addr;
   rf_word_t    rd_data;

   rf_word_t    shadow [PREGS];       // Expected contents of every register
   logic [31:0] lfsr = 32'haecf_1ed0;

   logic        rd_vld;    // A read was driven on this edge
   rf_word_t    rd_exp;    // What that read must return
   logic        chk_vld;   // Read data is due on the current edge
   rf_word_t    chk_exp;
   preg_t       chk_addr;

   regfile_top #(
      .PREGS (PREGS)
   ) i_dut (
      .clka     (clka),
      .reset    (reset),
      .alu_req  (alu_req),
      .alu_pkt  (alu_pkt),
      .alu_ack  (alu_ack),
      .bins_req (bins_req),
      .bins_pkt (bins_pkt),
      .bins_ack (bins_ack),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

   always #50 clka = ~clka;  // 100 ns period

   // ==============================
   // Stimulus and reference model
   // ==============================

   // Fibonacci LFSR with taps 32, 22, 2 and 1 that steps once per bit taken
   function automatic logic [31:0] lfsr_bits(int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic alu_issue_t rand_alu();
      alu_issue_t p;
      p.op  = alu_op_e'(3'(lfsr_bits(3) % 6));  // Only the six defined opcodes
      p.a   = lfsr_bits(32);
      p.b   = lfsr_bits(32);
      p.dst = preg_t'(lfsr_bits(PREG_W) % PREGS);
      return p;
   endfunction

   function automatic bins_issue_t rand_bins();
      bins_issue_t p;
      p.dst  = preg_t'(lfsr_bits(PREG_W) % PREGS);
      p.lane = lane_t'(lfsr_bits(LANE_W));
      p.data = 8'(lfsr_bits(8));
      return p;
   endfunction

   // New contents of a register after one committed operation
   function automatic rf_word_t predict(rf_word_t old, logic is_alu, alu_issue_t ap,
                                        bins_issue_t bp);
      rf_word_t w;
      w = old;
      if (is_alu) begin
         w.tag = src_alu;  // ALU replaces the whole word
         case (ap.op)
            alu_add: w.value = ap.a + ap.b;
            alu_sub: w.value = ap.a - ap.b;
            alu_and: w.value = ap.a & ap.b;
            alu_or:  w.value = ap.a | ap.b;
            alu_xor: w.value = ap.a ^ ap.b;
            alu_shl: w.value = ap.a << ap.b[4:0];
            default: w.value = '0;
         endcase
      end else begin
         w.tag   = src_binsert;
         // Clear the selected lane, then drop the new byte into it
         w.value = (w.value & ~(32'hff << (bp.lane * 8))) | (value_t'(bp.data) << (bp.lane * 8));
      end
      return w;
   endfunction

   task automatic give_up(string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "Simulation stopped at the first failure");
   endtask

   task automatic compare(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp) begin
         give_up($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   // Wait until the issue ack of one unit reaches the given level
   task automatic wait_ack(logic is_alu, logic level);
      int n;
      n = 0;
      while ((is_alu ? alu_ack : bins_ack) !== level) begin
         if (n == WAIT_LIMIT) begin
            give_up($sformatf("Timed out waiting for the %s issue ack to go %0b",
                              is_alu ? "ALU" : "byte-insert", level));
         end
         n++;
         @(posedge clka);
      end
   endtask

   // Full four-phase issue where req may stay high for extra cycles after the ack
   task automatic issue_op(logic is_alu, alu_issue_t ap, bins_issue_t bp, int hold);
      preg_t dst;
      dst = is_alu ? ap.dst : bp.dst;
      @(posedge clka);
      if (is_alu) begin
         alu_pkt <= ap;
         alu_req <= 1'b1;
      end else begin
         bins_pkt <= bp;
         bins_req <= 1'b1;
      end
      wait_ack(is_alu, 1'b1);
      shadow[dst] = predict(shadow[dst], is_alu, ap, bp);  // Ack order is write order
      for (int i = 0; i < hold; i++) begin
         @(posedge clka);
         compare(is_alu ? "alu_ack" : "bins_ack", 64'(is_alu ? alu_ack : bins_ack), 64'(1));
      end
      if (is_alu) alu_req <= 1'b0;
      else bins_req <= 1'b0;
      wait_ack(is_alu, 1'b0);
   endtask

   task automatic issue_pair(alu_issue_t ap, bins_issue_t bp);
      fork
         issue_op(1'b1, ap, bp, 0);
         issue_op(1'b0, ap, bp, 0);
      join
   endtask

   // Back-to-back reads that the compare process checks one by one
   task automatic read_regs(int first, int count);
      for (int i = first; i < first + count; i++) begin
         @(posedge clka);
         rd_addr <= preg_t'(i);
         rd_exp  <= shadow[i];
         rd_vld  <= 1'b1;
      end
      @(posedge clka);
      rd_vld <= 1'b0;
      repeat (2) @(posedge clka);  // Last read is compared on the first of these edges
   endtask

   // Read data belongs to the address driven two edges back
   always @(posedge clka) begin
      chk_vld  <= rd_vld;
      chk_exp  <= rd_exp;
      chk_addr <= rd_addr;
      if (chk_vld) begin
         compare($sformatf("rd_data[%0d]", chk_addr), 64'(rd_data), 64'(chk_exp));
      end
   end

   initial begin : stimulus
      alu_issue_t  ap;
      bins_issue_t bp;
      logic [31:0] kind;
      reset    <= 1'b1;
      alu_req  <= 1'b0;
      alu_pkt  <= '0;
      bins_req <= 1'b0;
      bins_pkt <= '0;
      rd_addr  <= '0;
      rd_vld   <= 1'b0;
      rd_exp   <= '0;
      for (int i = 0; i < PREGS; i++) begin
         shadow[i] = '0;  // RAM powers up cleared
      end
      repeat (4) @(posedge clka);
      reset <= 1'b0;
      read_regs(0, PREGS);
      // Every opcode twice with fresh operands
      for (int k = 0; k < 12; k++) begin
         ap    = rand_alu();
         ap.op = alu_op_e'(3'(k % 6));
         issue_op(1'b1, ap, '0, 0);
         read_regs(int'(ap.dst), 1);
      end
      // Byte insert into a freshly written word one lane at a time
      for (int k = 0; k < 4; k++) begin
         ap = rand_alu();
         issue_op(1'b1, ap, '0, 0);
         bp      = rand_bins();
         bp.dst  = ap.dst;
         bp.lane = lane_t'(k);
         issue_op(1'b0, '0, bp, 0);
         read_regs(int'(bp.dst), 1);
      end
      // Both units at once with a shared destination in odd rounds
      for (int k = 0; k < 8; k++) begin
         ap     = rand_alu();
         bp     = rand_bins();
         bp.dst = (k % 2 == 1) ? ap.dst : ap.dst ^ preg_t'(1);
         issue_pair(ap, bp);
         read_regs(int'(ap.dst), 1);
         read_regs(int'(bp.dst), 1);
      end
      // Slow source keeps req up after the ack
      for (int k = 0; k < 4; k++) begin
         ap = rand_alu();
         issue_op(1'b1, ap, '0, int'(lfsr_bits(3)) + 1);
         read_regs(int'(ap.dst), 1);
         bp = rand_bins();
         issue_op(1'b0, '0, bp, int'(lfsr_bits(3)) + 1);
         read_regs(int'(bp.dst), 1);
      end
      for (int k = 0; k < 200; k++) begin
         kind = lfsr_bits(2);
         ap   = rand_alu();
         bp   = rand_bins();
         case (kind)
            0:       issue_op(1'b1, ap, bp, 0);
            1:       issue_op(1'b0, ap, bp, 0);
            default: issue_pair(ap, bp);
         endcase
      end
      read_regs(0, PREGS);  // Whole file against the model
      $display("No errors");
      $finish;
   end

endmodule : regfile_tb

`default_nettype wire
